//--- Bender.yml
package:
  name: dma_mm2s

sources:
  - include_dirs:
      - source
    files:
      - source/dma_pkg.sv
      - source/dma_read_requester.sv
      - source/dma_realign_buffer.sv
      - source/dma_stream_framer.sv
      - source/dma_mm2s.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/dma_mm2s_asserts.sv
      - testbench/tb_dma_mm2s.sv

//--- dma_mm2s.f
+incdir+source
source/dma_pkg.sv
source/dma_read_requester.sv
source/dma_realign_buffer.sv
source/dma_stream_framer.sv
source/dma_mm2s.sv
testbench/dma_mm2s_asserts.sv
testbench/tb_dma_mm2s.sv

//--- source/dma_mm2s.sv
//////////////////////////////////////////////////////////////////////
// Memory-to-stream reader top
// Requester, realignment buffer and stream framer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dma_mm2s (
	input  wire                       i_clk,
	input  wire                       i_reset,
	// Request port
	input  wire                       i_request,
	input  wire dma_pkg::addr_t       i_addr,
	input  wire dma_pkg::len_t        i_len,
	output wire                       o_busy,
	output wire                       o_err,
	// Wishbone read master
	output wire                       o_rd_cyc,
	output wire                       o_rd_stb,
	output wire dma_pkg::word_addr_t  o_rd_addr,
	output wire dma_pkg::sel_t        o_rd_sel,
	input  wire                       i_rd_stall,
	input  wire                       i_rd_ack,
	input  wire dma_pkg::word_t       i_rd_data,
	input  wire                       i_rd_err,
	// Outgoing stream
	output wire                       o_m_valid,
	output wire dma_pkg::word_t       o_m_data,
	output wire dma_pkg::nbytes_t     o_m_bytes,
	output wire                       o_m_last
);

	import dma_pkg::*;

	wire nbytes_t ack_bytes;
	wire fill_t   fill;
	wire          emit;
	wire          done;

	// Bus side
	dma_read_requester u_requester (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_request  (i_request),
		.i_addr     (i_addr),
		.i_len      (i_len),
		.o_busy     (o_busy),
		.o_err      (o_err),
		.o_rd_cyc   (o_rd_cyc),
		.o_rd_stb   (o_rd_stb),
		.o_rd_addr  (o_rd_addr),
		.o_rd_sel   (o_rd_sel),
		.i_rd_stall (i_rd_stall),
		.i_rd_ack   (i_rd_ack),
		.i_rd_err   (i_rd_err),
		.i_done     (done)
	);

	// Byte packing
	dma_realign_buffer u_buffer (
		.i_clk       (i_clk),
		.i_busy      (o_busy),
		.i_addr      (i_addr),
		.i_rd_ack    (i_rd_ack),
		.i_rd_data   (i_rd_data),
		.i_ack_bytes (ack_bytes),
		.i_emit      (emit),
		.o_fill      (fill),
		.o_data      (o_m_data)
	);

	// Stream side
	dma_stream_framer u_framer (
		.i_clk       (i_clk),
		.i_busy      (o_busy),
		.i_addr      (i_addr),
		.i_len       (i_len),
		.i_rd_ack    (i_rd_ack),
		.i_fill      (fill),
		.o_ack_bytes (ack_bytes),
		.o_emit      (emit),
		.o_done      (done),
		.o_m_valid   (o_m_valid),
		.o_m_bytes   (o_m_bytes),
		.o_m_last    (o_m_last)
	);

endmodule

`default_nettype wire

//--- source/dma_mm2s_defs.svh
//////////////////////////////////////////////////////////////////////
// Sizing macros for the memory-to-stream reader
// Bus word size, byte address width and transfer length width
//////////////////////////////////////////////////////////////////////
`ifndef DMA_MM2S_DEFS_SVH
`define DMA_MM2S_DEFS_SVH

// Bytes per Wishbone word, also bytes per stream beat
`define DMA_BUS_BYTES 4

// Width of a byte address on the request port
`define DMA_ADDR_WIDTH 24

// Width of a byte length
// 11 bits, enough for a 1024 byte transfer
`define DMA_LEN_WIDTH 11

`endif

//--- source/dma_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the memory-to-stream reader
// Address, data, select and count vectors, requester state
//////////////////////////////////////////////////////////////////////
`default_nettype none

package dma_pkg;

	`include "dma_mm2s_defs.svh"

	// Byte and word addresses
	typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DMA_ADDR_WIDTH-$clog2(`DMA_BUS_BYTES)-1:0] word_addr_t;

	// One bus word or one stream beat, with its byte lanes
	typedef logic [8*`DMA_BUS_BYTES-1:0] word_t;
	typedef logic [`DMA_BUS_BYTES-1:0] sel_t;

	// Byte counts
	typedef logic [`DMA_LEN_WIDTH-1:0] len_t;
	// 0 to 4 bytes in one beat or one ack
	typedef logic [$clog2(`DMA_BUS_BYTES):0] nbytes_t;
	// 0 to 8 bytes held in the realigner
	typedef logic [$clog2(`DMA_BUS_BYTES)+1:0] fill_t;

	// Bus requester FSM
	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_ISSUE,
		REQ_DRAIN
	} req_state_e;

endpackage

`default_nettype wire

//--- source/dma_read_requester.sv
//////////////////////////////////////////////////////////////////////
// Wishbone pipelined read master of the memory-to-stream reader
// Busy and error control, strobe sequencing, byte selects,
// count of reads still waiting for an ack
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "dma_mm2s_defs.svh"

module dma_read_requester (
	input  wire                 i_clk,
	input  wire                 i_reset,
	// Request port
	input  wire                 i_request,
	input  wire dma_pkg::addr_t i_addr,
	input  wire dma_pkg::len_t  i_len,
	output logic                o_busy,
	output logic                o_err,
	// Wishbone master
	output logic                o_rd_cyc,
	output logic                o_rd_stb,
	output dma_pkg::word_addr_t o_rd_addr,
	output dma_pkg::sel_t       o_rd_sel,
	input  wire                 i_rd_stall,
	input  wire                 i_rd_ack,
	input  wire                 i_rd_err,
	// Last beat sent by the framer
	input  wire                 i_done
);

	import dma_pkg::*;

	localparam int BUS_BYTES = `DMA_BUS_BYTES;
	localparam int OFF_W = $clog2(BUS_BYTES);
	localparam sel_t SEL_ALL = '1;

	req_state_e r_state;
	len_t       stb_left;
	len_t       outstanding;
	sel_t       last_sel;

	addr_t      last_addr;
	word_addr_t first_word;
	word_addr_t last_word;
	len_t       word_count;
	sel_t       first_sel;
	sel_t       end_sel;
	logic       accept;

	//////////////////////////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Address of the final byte of the transfer
		last_addr = i_addr + addr_t'(i_len) - addr_t'(1);
		first_word = i_addr[`DMA_ADDR_WIDTH-1:OFF_W];
		last_word = last_addr[`DMA_ADDR_WIDTH-1:OFF_W];
		// Words touched, at most 257 for a 1024 byte transfer
		word_count = len_t'(last_word - first_word) + len_t'(1);
		// Big-endian lanes, byte offset 0 sits in sel bit 3
		first_sel = SEL_ALL >> i_addr[OFF_W-1:0];
		end_sel = SEL_ALL << (BUS_BYTES - 1 - int'(last_addr[OFF_W-1:0]));
	end

	assign accept = o_rd_stb && !i_rd_stall;
	assign o_busy = (r_state != REQ_IDLE);

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_state <= REQ_IDLE;
			o_rd_cyc <= 1'b0;
			o_rd_stb <= 1'b0;
			o_err <= 1'b0;
			stb_left <= '0;
		end
		else if (o_rd_cyc && i_rd_err)
		begin
			// Bus error, abandon the transfer
			r_state <= REQ_IDLE;
			o_rd_cyc <= 1'b0;
			o_rd_stb <= 1'b0;
			o_err <= 1'b1;
		end
		else
		begin
			case (r_state)
			REQ_IDLE:
				if (i_request)
				begin
					r_state <= REQ_ISSUE;
					o_rd_cyc <= 1'b1;
					o_rd_stb <= 1'b1;
					// Sticky error cleared by a new request only
					o_err <= 1'b0;
					stb_left <= word_count;
				end
			REQ_ISSUE:
				if (accept)
				begin
					if (stb_left == len_t'(1))
					begin
						// Final word accepted
						o_rd_stb <= 1'b0;
						r_state <= REQ_DRAIN;
					end
					else
						stb_left <= stb_left - len_t'(1);
				end
			REQ_DRAIN:
				if (i_done)
				begin
					r_state <= REQ_IDLE;
					o_rd_cyc <= 1'b0;
				end
				else if (i_rd_ack && outstanding == len_t'(1))
					// Last ack in, release the bus
					o_rd_cyc <= 1'b0;
			default:
				r_state <= REQ_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Word address and byte select
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (r_state == REQ_IDLE)
		begin
			o_rd_addr <= first_word;
			last_sel <= end_sel;
			// Single word transfer trims both ends
			if (word_count == len_t'(1))
				o_rd_sel <= first_sel & end_sel;
			else
				o_rd_sel <= first_sel;
		end
		else if (r_state == REQ_ISSUE && accept)
		begin
			o_rd_addr <= o_rd_addr + word_addr_t'(1);
			// Next strobe is the last word
			if (stb_left == len_t'(2))
				o_rd_sel <= last_sel;
			else
				o_rd_sel <= SEL_ALL;
		end
	end

	// Reads accepted but not yet acknowledged
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !o_rd_cyc)
			outstanding <= '0;
		else
		begin
			case ({accept, i_rd_ack})
			2'b10: outstanding <= outstanding + len_t'(1);
			2'b01: outstanding <= outstanding - len_t'(1);
			default: outstanding <= outstanding;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/dma_realign_buffer.sv
//////////////////////////////////////////////////////////////////////
// Two-word realignment register
// Packs acknowledged bytes left-justified for the stream
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dma_realign_buffer (
	input  wire                  i_clk,
	input  wire                  i_busy,
	input  wire dma_pkg::addr_t  i_addr,
	input  wire                  i_rd_ack,
	input  wire dma_pkg::word_t  i_rd_data,
	input  wire dma_pkg::nbytes_t i_ack_bytes,
	input  wire                  i_emit,
	output dma_pkg::fill_t       o_fill,
	output dma_pkg::word_t       o_data
);

	import dma_pkg::*;

	localparam int WORD_W = $bits(word_t);
	localparam int BUS_BYTES = WORD_W / 8;
	localparam int OFF_W = $clog2(BUS_BYTES);

	// Upper word is the outgoing beat
	logic [2*WORD_W-1:0] sreg;
	logic [2*WORD_W-1:0] base;
	logic [2*WORD_W-1:0] incoming;
	logic [OFF_W-1:0]    pre_shift;
	fill_t               base_fill;
	word_t               shifted;
	word_t               keep_mask;

	always_comb
	begin
		// Drop the bytes below the start address
		shifted = i_rd_data << (8 * pre_shift);
		// Keep only the bytes this ack contributes
		keep_mask = ~({WORD_W{1'b1}} >> (8 * i_ack_bytes));

		// Beat leaving this edge frees the upper word
		if (i_emit)
		begin
			base = {sreg[WORD_W-1:0], {WORD_W{1'b0}}};
			if (o_fill > fill_t'(BUS_BYTES))
				base_fill = o_fill - fill_t'(BUS_BYTES);
			else
				base_fill = '0;
		end
		else
		begin
			base = sreg;
			base_fill = o_fill;
		end

		// New bytes go just below the bytes already held
		incoming = {shifted & keep_mask, {WORD_W{1'b0}}} >> (8 * base_fill);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_busy)
		begin
			sreg <= '0;
			o_fill <= '0;
			pre_shift <= i_addr[OFF_W-1:0];
		end
		else if (i_rd_ack)
		begin
			sreg <= base | incoming;
			o_fill <= base_fill + fill_t'(i_ack_bytes);
			// Later words start on a word boundary
			pre_shift <= '0;
		end
		else
		begin
			sreg <= base;
			o_fill <= base_fill;
		end
	end

	assign o_data = sreg[2*WORD_W-1:WORD_W];

endmodule

`default_nettype wire

//--- source/dma_stream_framer.sv
//////////////////////////////////////////////////////////////////////
// Stream framer of the memory-to-stream reader
// Byte accounting per ack, beat valid, byte count and last flag
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "dma_mm2s_defs.svh"

module dma_stream_framer (
	input  wire                  i_clk,
	input  wire                  i_busy,
	input  wire dma_pkg::addr_t  i_addr,
	input  wire dma_pkg::len_t   i_len,
	input  wire                  i_rd_ack,
	input  wire dma_pkg::fill_t  i_fill,
	output dma_pkg::nbytes_t     o_ack_bytes,
	output logic                 o_emit,
	output logic                 o_done,
	output logic                 o_m_valid,
	output dma_pkg::nbytes_t     o_m_bytes,
	output logic                 o_m_last
);

	import dma_pkg::*;

	localparam int BUS_BYTES = `DMA_BUS_BYTES;
	localparam int OFF_W = $clog2(BUS_BYTES);

	// Bytes not yet acknowledged
	len_t             rem_bytes;
	logic             first_ack;
	logic [OFF_W-1:0] start_off;

	nbytes_t avail_bytes;
	fill_t   held;
	fill_t   next_fill;
	len_t    rem_next;

	//////////////////////////////////////////////////////////////////////
	// Ack accounting
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// First word loses the bytes below the start offset
		if (first_ack)
			avail_bytes = nbytes_t'(BUS_BYTES - int'(start_off));
		else
			avail_bytes = nbytes_t'(BUS_BYTES);

		// Capped by what is left of the length
		if (rem_bytes < len_t'(avail_bytes))
			o_ack_bytes = nbytes_t'(rem_bytes);
		else
			o_ack_bytes = avail_bytes;

		// Bytes left once the current beat is gone
		held = i_fill - (o_m_valid ? fill_t'(o_m_bytes) : fill_t'(0));
		next_fill = held + (i_rd_ack ? fill_t'(o_ack_bytes) : fill_t'(0));
		rem_next = i_rd_ack ? rem_bytes - len_t'(o_ack_bytes) : rem_bytes;
	end

	//////////////////////////////////////////////////////////////////////
	// Beat generation
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_busy)
		begin
			o_m_valid <= 1'b0;
			o_m_last <= 1'b0;
			o_m_bytes <= '0;
			rem_bytes <= i_len;
			first_ack <= 1'b1;
			start_off <= i_addr[OFF_W-1:0];
		end
		else
		begin
			if (i_rd_ack)
			begin
				rem_bytes <= rem_next;
				first_ack <= 1'b0;
			end

			o_m_valid <= 1'b0;
			o_m_last <= 1'b0;
			// Nothing follows the last beat
			if (!(o_m_valid && o_m_last))
			begin
				if (next_fill >= fill_t'(BUS_BYTES))
				begin
					// Full word ready
					o_m_valid <= 1'b1;
					o_m_bytes <= nbytes_t'(BUS_BYTES);
					o_m_last <= (rem_next == '0) &&
						(next_fill == fill_t'(BUS_BYTES));
				end
				else if (rem_next == '0 && next_fill != '0)
				begin
					// Tail bytes after the final ack
					o_m_valid <= 1'b1;
					o_m_bytes <= nbytes_t'(next_fill);
					o_m_last <= 1'b1;
				end
			end
		end
	end

	// Realigner shifts as each beat leaves
	assign o_emit = o_m_valid;
	assign o_done = o_m_valid && o_m_last;

endmodule

`default_nettype wire

//--- testbench/dma_mm2s_asserts.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the Wishbone and stream ports of the reader
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dma_mm2s_asserts (
	input wire                   i_clk,
	input wire                   i_reset,
	input wire                   i_busy,
	input wire                   i_rd_cyc,
	input wire                   i_rd_stb,
	input wire                   i_m_valid,
	input wire dma_pkg::nbytes_t i_m_bytes,
	input wire                   i_m_last
);

	// Strobe only inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rd_stb |-> i_rd_cyc)
		else $error("stb high while cyc is low");

	// A beat carries 1 to 4 bytes
	a_beat_bytes: assert property (@(posedge i_clk) disable iff (i_reset)
		i_m_valid |-> (i_m_bytes >= 1 && i_m_bytes <= 4))
		else $error("beat byte count out of range");

	// Last only on a valid beat
	a_last_valid: assert property (@(posedge i_clk) disable iff (i_reset)
		i_m_last |-> i_m_valid)
		else $error("last high without valid");

	// Idle straight out of reset
	a_idle_after_reset: assert property (@(posedge i_clk)
		i_reset |=> !i_busy)
		else $error("busy high after reset");

endmodule

bind dma_mm2s dma_mm2s_asserts u_asserts (
	.i_clk     (i_clk),
	.i_reset   (i_reset),
	.i_busy    (o_busy),
	.i_rd_cyc  (o_rd_cyc),
	.i_rd_stb  (o_rd_stb),
	.i_m_valid (o_m_valid),
	.i_m_bytes (o_m_bytes),
	.i_m_last  (o_m_last)
);

`default_nettype wire

//--- testbench/tb_dma_mm2s.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the memory-to-stream reader
// Clock and reset, Wishbone memory model, directed tests, summary
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "dma_mm2s_defs.svh"

module tb_dma_mm2s;

	import dma_pkg::*;

	localparam int BUS_BYTES = `DMA_BUS_BYTES;
	localparam int MEM_BYTES = 1024;
	// About 40 cycles per random transfer plus the directed tests and margin
	localparam int MAX_CYCLES = 3000;

	logic       i_clk = 1'b0;
	logic       i_reset;
	logic       i_request;
	addr_t      i_addr;
	len_t       i_len;
	logic       i_rd_stall;
	logic       i_rd_ack;
	word_t      i_rd_data;
	logic       i_rd_err;
	wire        o_busy;
	wire        o_err;
	wire        o_rd_cyc;
	wire        o_rd_stb;
	word_addr_t o_rd_addr;
	sel_t       o_rd_sel;
	wire        o_m_valid;
	word_t      o_m_data;
	nbytes_t    o_m_bytes;
	wire        o_m_last;

	integer seed = 32'h9d6;
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	int     tests = 0;
	// Index of the read that returns an error ack or -1 for none
	int     err_read = -1;
	int     ack_index = 0;
	// Last beat seen at the previous falling edge
	bit     last_seen = 1'b0;

	logic [7:0] mem [MEM_BYTES];
	// Accepted reads waiting for their ack and the cycle they are due
	word_addr_t pend_addr[$];
	int         pend_due[$];
	// Logged strobes and stream beats of the current transfer
	word_addr_t stb_addr[$];
	sel_t       stb_sel[$];
	word_t      beat_data[$];
	nbytes_t    beat_bytes[$];
	bit         beat_last[$];

	dma_mm2s i_dut (.*);

	always #50 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	// Big-endian word from the byte memory that wraps at 1 KiB
	function automatic word_t read_word(input word_addr_t wa);
		int base;
		base = BUS_BYTES * int'(wa[7:0]);
		read_word = {mem[base], mem[base+1], mem[base+2], mem[base+3]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Wishbone slave and stream monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin : bus_slave
		word_addr_t wa;
		i_rd_ack = 1'b0;
		i_rd_err = 1'b0;
		i_rd_data = '0;
		// In order ack of the oldest read once its delay is over
		if (o_rd_cyc && pend_addr.size() > 0 && pend_due[0] <= cycles)
		begin
			wa = pend_addr.pop_front();
			void'(pend_due.pop_front());
			if (ack_index == err_read)
			begin
				i_rd_err = 1'b1;
				err_read = -1;
				pend_addr.delete();
				pend_due.delete();
			end
			else
			begin
				i_rd_ack = 1'b1;
				i_rd_data = read_word(wa);
			end
			ack_index = ack_index + 1;
		end
		i_rd_stall = (($random(seed) & 3) == 0);
		// Read taken at the coming rising edge
		if (o_rd_stb && !i_rd_stall && !i_rd_err && !i_reset)
		begin
			pend_addr.push_back(o_rd_addr);
			pend_due.push_back(cycles + 1 + ($random(seed) & 3));
			stb_addr.push_back(o_rd_addr);
			stb_sel.push_back(o_rd_sel);
		end
	end

	// Beat log and the busy drop one cycle after the last beat
	always @(negedge i_clk)
	begin
		if (last_seen)
			check_flag(o_busy, 1'b0, "busy after last beat");
		last_seen = o_m_valid && o_m_last;
		if (o_m_valid)
		begin
			beat_data.push_back(o_m_data);
			beat_bytes.push_back(o_m_bytes);
			beat_last.push_back(o_m_last);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bytes(input nbytes_t got, input nbytes_t exp, input string what);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_sel(input sel_t got, input sel_t exp, input string what);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Transfer helpers
	//////////////////////////////////////////////////////////////////////

	// One request pulse and a wait for the reader to go idle
	task automatic issue_request(input int addr, input int len);
		@(negedge i_clk);
		stb_addr.delete();
		stb_sel.delete();
		beat_data.delete();
		beat_bytes.delete();
		beat_last.delete();
		ack_index = 0;
		i_addr = addr_t'(addr);
		i_len = len_t'(len);
		i_request = 1'b1;
		@(negedge i_clk);
		i_request = 1'b0;
		// Request taken at the edge just passed
		check_flag(o_busy, 1'b1, "busy after request");
		check_flag(o_rd_cyc, 1'b1, "cyc after request");
		check_flag(o_rd_stb, 1'b1, "stb after request");
		while (o_busy)
			@(negedge i_clk);
	endtask

	// Beats and strobes against the byte memory
	task automatic check_transfer(input int addr, input int len);
		int    nbeats;
		int    nb;
		int    first_w;
		int    nwords;
		int    b;
		word_t exp_data;
		word_t mask;
		sel_t  exp_sel;
		nbeats = (len + BUS_BYTES - 1) / BUS_BYTES;
		check_word(word_t'(beat_data.size()), word_t'(nbeats), "beat count");
		for (int i = 0; i < beat_data.size() && i < nbeats; i++)
		begin
			// Full beats with the remainder on the last one
			nb = (i == nbeats - 1) ? len - BUS_BYTES * i : BUS_BYTES;
			exp_data = '0;
			mask = '0;
			for (int j = 0; j < nb; j++)
			begin
				exp_data[31-8*j -: 8] = mem[addr + BUS_BYTES * i + j];
				mask[31-8*j -: 8] = 8'hff;
			end
			check_word(beat_data[i] & mask, exp_data, "beat data");
			check_bytes(beat_bytes[i], nbytes_t'(nb), "beat bytes");
			check_flag(beat_last[i], i == nbeats - 1, "beat last");
		end
		first_w = addr / BUS_BYTES;
		nwords = (addr + len - 1) / BUS_BYTES - first_w + 1;
		check_word(word_t'(stb_addr.size()), word_t'(nwords), "strobe count");
		for (int w = 0; w < stb_addr.size() && w < nwords; w++)
		begin
			check_word(word_t'(stb_addr[w]), word_t'(first_w + w), "strobe address");
			// Lane 3 holds the lowest byte address of the word
			for (int k = 0; k < BUS_BYTES; k++)
			begin
				b = BUS_BYTES * (first_w + w) + k;
				exp_sel[BUS_BYTES-1-k] = (b >= addr) && (b < addr + len);
			end
			check_sel(stb_sel[w], exp_sel, "strobe select");
		end
		check_flag(o_rd_cyc, 1'b0, "cyc after transfer");
		check_flag(o_err, 1'b0, "error flag");
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests = tests + 1;
		$display("test %s finished with %0d errors", name, errors - start_errors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_aligned();
		int start;
		start = errors;
		issue_request(0, 16);
		check_transfer(0, 16);
		report_test("aligned", start);
	endtask

	task automatic test_unaligned();
		int start;
		start = errors;
		issue_request(5, 10);
		check_transfer(5, 10);
		issue_request(99, 23);
		check_transfer(99, 23);
		report_test("unaligned", start);
	endtask

	task automatic test_select_masks();
		int start;
		start = errors;
		issue_request(6, 9);
		check_transfer(6, 9);
		// Both ends inside one word
		issue_request(13, 2);
		check_transfer(13, 2);
		report_test("select masks", start);
	endtask

	task automatic test_random_transfers();
		int start;
		int addr;
		int len;
		start = errors;
		for (int n = 0; n < 20; n++)
		begin
			len = 1 + ($random(seed) & 63);
			addr = $random(seed) & (MEM_BYTES - 1);
			if (addr + len > MEM_BYTES)
				addr = MEM_BYTES - len;
			issue_request(addr, len);
			check_transfer(addr, len);
		end
		report_test("random transfers", start);
	endtask

	task automatic test_bus_error();
		int start;
		start = errors;
		// Second read of eight returns an error
		err_read = 1;
		issue_request(8, 32);
		repeat (2) @(negedge i_clk);
		if (err_read >= 0)
		begin
			errors = errors + 1;
			$display("error ack was never driven during the transfer");
		end
		check_flag(o_err, 1'b1, "error flag after error ack");
		check_flag(o_busy, 1'b0, "busy after error ack");
		check_flag(o_rd_cyc, 1'b0, "cyc after error ack");
		check_flag(o_rd_stb, 1'b0, "stb after error ack");
		foreach (beat_last[i])
			check_flag(beat_last[i], 1'b0, "last after error ack");
		// Clean request clears the sticky flag
		issue_request(40, 12);
		check_transfer(40, 12);
		report_test("bus error", start);
	endtask

	task automatic test_single_byte();
		int start;
		start = errors;
		issue_request(3, 1);
		check_transfer(3, 1);
		check_word(beat_data[0] & 32'hff00_0000, {mem[3], 24'h0}, "single byte lane");
		report_test("single byte", start);
	endtask

	initial
	begin
		i_reset = 1'b1;
		i_request = 1'b0;
		i_addr = '0;
		i_len = len_t'(1);
		i_rd_stall = 1'b0;
		i_rd_ack = 1'b0;
		i_rd_data = '0;
		i_rd_err = 1'b0;
		for (int n = 0; n < MEM_BYTES; n++)
			mem[n] = $random(seed);
		repeat (2) @(negedge i_clk);
		i_reset = 1'b0;

		test_aligned();
		test_unaligned();
		test_select_masks();
		test_random_transfers();
		test_bus_error();
		test_single_byte();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
